// File: host_boot_mem.f
+incdir+rtl
rtl/dmem_pkg.sv
rtl/host_pkg.sv
rtl/boot_loader.sv
rtl/dmem_arbiter.sv
rtl/data_mem.sv
rtl/host_boot_mem.sv
dv/tb_clk_gen.sv
dv/host_boot_mem_chk.sv
dv/tb_host_boot_mem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the host boot memory testbench with Verilator and run it
# the run passes only if the pass message shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f host_boot_mem.f --top-module tb_host_boot_mem -Mdir obj_dir \
    && ./obj_dir/Vtb_host_boot_mem +verilator+error+limit+100 \
        | tee /dev/stderr | grep -q "Finished with no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: dv/tb_host_boot_mem.sv
// testbench for the host boot memory
// host model loads the image, then the accelerator port is exercised
// against a shadow copy of every word written

`timescale 1ns/100ps

`include "host_boot_macros.svh"

module tb_host_boot_mem;

    // 17 regions x 20 cycles plus about 200 accelerator cycles and margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int LINE_BYTES     = `HBM_LINE_WORDS * `HBM_WORD_BYTES;

    logic                  clk;
    logic                  rst_n;
    logic                  ready;
    logic                  rd_valid;
    logic                  tx_done;
    dmem_pkg::word_t       ex_wrt_data;
    host_pkg::host_op_t    op;
    dmem_pkg::byte_addr_t  ex_addr;
    dmem_pkg::byte_addr_t  accel_addr;
    dmem_pkg::word_t       accel_wrt_data;
    logic                  accel_wrt_en;
    logic                  accel_rd_en;
    logic                  accel_wrt_done;
    logic                  accel_rd_valid;
    dmem_pkg::line_t       accel_rd_data;

    logic [31:0]           lfsr = 32'h4b8de1e0;
    dmem_pkg::word_t       shadow [0:`HBM_DM_WORDS-1];  // what memory should hold
    dmem_pkg::line_t       exp_lines [$];
    string                 exp_names [$];
    logic                  booted_tb = 1'b0;
    logic                  rd_due = 1'b0;     // pulse owed this cycle
    logic                  wr_due = 1'b0;
    int                    cycles = 0;

    tb_clk_gen i_clk_gen (.clk, .rst_n);

    host_boot_mem i_dut (.*);

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    // galois lfsr x^32+x^22+x^2+x+1 stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic dmem_pkg::line_t expected_line(input dmem_pkg::byte_addr_t addr);
        dmem_pkg::line_t line;
        int              base;
        base = (int'(addr) / LINE_BYTES) * `HBM_LINE_WORDS;   // aligned down
        for (int w = 0; w < `HBM_LINE_WORDS; w++)
            line[w*`HBM_WORD_BITS +: `HBM_WORD_BITS] = shadow[base + w];
        return line;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "run stopped at cycle %0d", cycles);
    endtask

    task automatic check_line(input string name, input dmem_pkg::line_t exp,
                              input dmem_pkg::line_t act);
        if (act !== exp)
            stop_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_addr(input string name, input dmem_pkg::byte_addr_t exp,
                              input dmem_pkg::byte_addr_t act);
        if (act !== exp)
            stop_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_op(input string name, input host_pkg::host_op_t exp,
                            input host_pkg::host_op_t act);
        if (act !== exp)
            stop_run($sformatf("MISMATCH %s expected %s actual %s", name, exp.name(),
                               act.name()));
    endtask

    task automatic check_pulse(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
    endtask

    //////////////////////////////////////////////////////////////////////
    // host model
    //////////////////////////////////////////////////////////////////////

    task automatic load_region(input int r);
        dmem_pkg::word_t word;
        int              gap;
        do
            @(negedge clk);
        while (op !== host_pkg::HOST_READ);
        check_addr($sformatf("region%0d_base", r), host_pkg::BOOT_REGION_BASE[r], ex_addr);
        gap = int'(rand_bits(2));   // 0 to 3 cycles before the first word
        repeat (gap) @(posedge clk);
        for (int w = 0; w < `HBM_LINE_WORDS; w++) begin
            word = rand_bits(`HBM_WORD_BITS);
            @(posedge clk);
            rd_valid    <= (w == 0);
            tx_done     <= (w == `HBM_LINE_WORDS - 1);
            ex_wrt_data <= word;
            shadow[int'(host_pkg::BOOT_REGION_BASE[r]) / `HBM_WORD_BYTES + w] = word;
        end
        @(posedge clk);
        rd_valid <= 1'b0;
        tx_done  <= 1'b0;
    endtask

    task automatic run_boot();
        @(posedge clk);
        ready <= 1'b1;
        for (int r = 0; r < `HBM_NUM_REGIONS; r++)
            load_region(r);
        booted_tb = 1'b1;   // last tx_done taken on this edge
        @(negedge clk);
        check_op("boot_end_op", host_pkg::HOST_IDLE, op);
    endtask

    // accelerator strobes while loading must all be ignored
    task automatic boot_noise();
        repeat (100) begin
            @(posedge clk);
            accel_addr     <= host_pkg::BOOT_REGION_BASE[rand_bits(4)];
            accel_wrt_data <= rand_bits(32);
            accel_wrt_en   <= (rand_bits(1) != 0);
            accel_rd_en    <= (rand_bits(1) != 0);
        end
        @(posedge clk);
        accel_wrt_en <= 1'b0;
        accel_rd_en  <= 1'b0;
    endtask

    task automatic accel_cmd(input string name, input logic rd, input logic wr,
                             input dmem_pkg::byte_addr_t addr, input dmem_pkg::word_t data);
        @(posedge clk);
        accel_rd_en    <= rd;
        accel_wrt_en   <= wr;
        accel_addr     <= addr;
        accel_wrt_data <= data;
        if (rd) begin
            exp_lines.push_back(expected_line(addr));  // taken before the write so old data
            exp_names.push_back(name);
        end
        if (wr)
            shadow[int'(addr) / `HBM_WORD_BYTES] = data;
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare and timeout
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_n) begin
            check_pulse("wrt_done_pulse", wr_due, accel_wrt_done);
            check_pulse("rd_valid_pulse", rd_due, accel_rd_valid);
            if (accel_rd_valid === 1'b1)
                check_line(exp_names.pop_front(), exp_lines.pop_front(), accel_rd_data);
            if (i_dut.i_chk.fail_seen)
                stop_run("an assertion in host_boot_mem_chk failed");
        end
        wr_due = booted_tb && accel_wrt_en;
        rd_due = booted_tb && accel_rd_en;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
            stop_run("timeout, the test did not finish within the cycle limit");
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        dmem_pkg::byte_addr_t addr;
        ready          <= 1'b0;
        rd_valid       <= 1'b0;
        tx_done        <= 1'b0;
        ex_wrt_data    <= '0;
        accel_addr     <= '0;
        accel_wrt_data <= '0;
        accel_wrt_en   <= 1'b0;
        accel_rd_en    <= 1'b0;
        wait (rst_n === 1'b1);

        repeat (5) begin    // ready still low
            @(negedge clk);
            check_op("reset_op", host_pkg::HOST_IDLE, op);
            check_addr("reset_addr", '0, ex_addr);
        end

        fork
            run_boot();
            boot_noise();
        join

        // one line per region at a random offset inside it
        for (int r = 0; r < `HBM_NUM_REGIONS; r++) begin
            addr = host_pkg::BOOT_REGION_BASE[r] + dmem_pkg::byte_addr_t'(rand_bits(6));
            accel_cmd($sformatf("region%0d_line", r), 1'b1, 1'b0, addr, '0);
            accel_cmd("idle", 1'b0, 1'b0, '0, '0);
        end

        for (int i = 0; i < 8; i++) begin
            addr = host_pkg::BOOT_REGION_BASE[rand_bits(4)]
                 + dmem_pkg::byte_addr_t'(4 * rand_bits(4));
            accel_cmd("write", 1'b0, 1'b1, addr, rand_bits(32));
            accel_cmd("idle", 1'b0, 1'b0, '0, '0);
            accel_cmd($sformatf("write%0d_readback", i), 1'b1, 1'b0, addr, '0);
        end

        addr = host_pkg::BOOT_REGION_BASE[rand_bits(4)] + dmem_pkg::byte_addr_t'(8);
        accel_cmd("rw_same_cycle", 1'b1, 1'b1, addr, rand_bits(32));
        accel_cmd("rw_after", 1'b1, 1'b0, addr, '0);

        for (int r = 0; r < `HBM_NUM_REGIONS; r++) begin     // one read per cycle
            addr = host_pkg::BOOT_REGION_BASE[r] + dmem_pkg::byte_addr_t'(rand_bits(6));
            accel_cmd($sformatf("b2b%0d_line", r), 1'b1, 1'b0, addr, '0);
        end
        accel_cmd("idle", 1'b0, 1'b0, '0, '0);

        while (exp_lines.size() != 0)
            @(negedge clk);
        @(negedge clk);

        if (!i_dut.i_chk.fail_seen) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            stop_run("an assertion in host_boot_mem_chk failed");
        end
    end

endmodule

// File: dv/host_boot_mem_chk.sv
// handshake assertions for the host boot memory top level
// bound into host_boot_mem, watches op and the accelerator pulses

`timescale 1ns/100ps

module host_boot_mem_chk (
    input logic                clk,
    input logic                rst_n,
    input host_pkg::host_op_t  op,
    input logic                booted,
    input logic                accel_rd_en,
    input logic                accel_rd_valid,
    input logic                accel_wrt_done
);

    logic rd_seen;              // a line read has come back
    logic fail_seen = 1'b0;     // sticky, any assertion failed

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rd_seen <= 1'b0;
        else if (accel_rd_valid)
            rd_seen <= 1'b1;
    end

    // boot is over for good once the accelerator gets data
    a_no_read_after_valid: assert property (
        @(posedge clk) disable iff (!rst_n) rd_seen |-> op != host_pkg::HOST_READ
    ) else begin
        $error("op went back to HOST_READ after a line read");
        fail_seen = 1'b1;
    end

    a_rd_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        booted && op == host_pkg::HOST_IDLE |=> accel_rd_valid == $past(accel_rd_en)
    ) else begin
        $error("accel_rd_valid not one cycle after accel_rd_en");
        fail_seen = 1'b1;
    end

    // strobes are masked while the image loads
    a_no_done_in_boot: assert property (
        @(posedge clk) disable iff (!rst_n) !booted |-> !accel_wrt_done
    ) else begin
        $error("accel_wrt_done pulsed before boot completed");
        fail_seen = 1'b1;
    end

endmodule

bind host_boot_mem host_boot_mem_chk i_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .op             (op),
    .booted         (booted),
    .accel_rd_en    (accel_rd_en),
    .accel_rd_valid (accel_rd_valid),
    .accel_wrt_done (accel_wrt_done)
);

// File: dv/tb_clk_gen.sv
// testbench clock and reset
// free running clock, active low reset held for the first edges

`timescale 1ns/100ps

module tb_clk_gen #(
    parameter real PERIOD_NS    = 40.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;      // released on a rising edge
    end

endmodule

// File: rtl/host_boot_mem.sv
// host boot memory top level
// boot loader fetches the data image from the host, then the
// accelerator gets word writes and line reads on the same memory

`timescale 1ns/100ps

module host_boot_mem (
    input  logic                  clk,
    input  logic                  rst_n,
    // host side
    input  logic                  ready,
    input  logic                  rd_valid,
    input  logic                  tx_done,
    input  dmem_pkg::word_t       ex_wrt_data,
    output host_pkg::host_op_t    op,
    output dmem_pkg::byte_addr_t  ex_addr,
    // accelerator side
    input  dmem_pkg::byte_addr_t  accel_addr,
    input  dmem_pkg::word_t       accel_wrt_data,
    input  logic                  accel_wrt_en,
    input  logic                  accel_rd_en,
    output logic                  accel_wrt_done,
    output logic                  accel_rd_valid,
    output dmem_pkg::line_t       accel_rd_data
);

    // loader to arbiter
    logic                  booted;
    logic                  ld_wr_en;
    dmem_pkg::byte_addr_t  ld_wr_addr;
    dmem_pkg::word_t       ld_wr_data;

    // arbiter to memory
    logic                  mem_wr_en;
    dmem_pkg::word_idx_t   mem_wr_idx;
    dmem_pkg::word_t       mem_wr_data;
    logic                  mem_rd_en;
    logic [8:0]            mem_rd_line;
    dmem_pkg::line_t       rd_line;

    boot_loader i_loader (
        .clk, .rst_n,
        .ready, .rd_valid, .tx_done, .ex_wrt_data,
        .op, .ex_addr,
        .booted, .ld_wr_en, .ld_wr_addr, .ld_wr_data
    );

    dmem_arbiter i_arb (
        .clk, .rst_n,
        .booted, .ld_wr_en, .ld_wr_addr, .ld_wr_data,
        .accel_addr, .accel_wrt_data, .accel_wrt_en, .accel_rd_en,
        .rd_line,
        .mem_wr_en, .mem_wr_idx, .mem_wr_data, .mem_rd_en, .mem_rd_line,
        .accel_wrt_done, .accel_rd_valid, .accel_rd_data
    );

    data_mem i_mem (
        .clk,
        .wr_en       (mem_wr_en),
        .wr_idx      (mem_wr_idx),
        .wr_data     (mem_wr_data),
        .rd_en       (mem_rd_en),
        .rd_line_idx (mem_rd_line),
        .rd_line     (rd_line)
    );

endmodule

// File: rtl/data_mem.sv
// banked data memory
// sixteen word-wide banks so a whole line comes out in one access;
// word writes on the clock edge, registered line reads

`timescale 1ns/100ps

`include "host_boot_macros.svh"

module data_mem (
    input  logic                 clk,
    input  logic                 wr_en,
    input  dmem_pkg::word_idx_t  wr_idx,
    input  dmem_pkg::word_t      wr_data,
    input  logic                 rd_en,
    input  logic [8:0]           rd_line_idx,
    output dmem_pkg::line_t      rd_line
);

    localparam int BANK_BITS = $clog2(`HBM_LINE_WORDS);
    localparam int ROWS      = `HBM_DM_WORDS / `HBM_LINE_WORDS;
    localparam int IDX_BITS  = $bits(dmem_pkg::word_idx_t);

    logic [BANK_BITS-1:0]          wr_bank;
    logic [IDX_BITS-BANK_BITS-1:0] wr_row;

    // word index mod 16 picks the bank, the rest picks the row
    assign wr_bank = wr_idx[BANK_BITS-1:0];
    assign wr_row  = wr_idx[IDX_BITS-1:BANK_BITS];

    //////////////////////////////////////////////////////////////////////
    // banks
    //////////////////////////////////////////////////////////////////////

    for (genvar b = 0; b < `HBM_LINE_WORDS; b++) begin : g_bank

        dmem_pkg::word_t  mem [0:ROWS-1];   // powers up undefined
        dmem_pkg::word_t  rd_q;
        logic             bank_we;

        assign bank_we = wr_en && (wr_bank == BANK_BITS'(b));

        always_ff @(posedge clk) begin
            if (bank_we)
                mem[wr_row] <= wr_data;
        end

        // same-edge write is not seen, old word comes back
        always_ff @(posedge clk) begin
            if (rd_en)
                rd_q <= mem[rd_line_idx];
        end

        assign rd_line[b*`HBM_WORD_BITS +: `HBM_WORD_BITS] = rd_q;    // word b in slot b

    end

endmodule

// File: rtl/dmem_arbiter.sv
// data memory arbiter
// loader owns the write port during boot, the accelerator afterwards;
// accelerator strobes are masked until boot ends

`timescale 1ns/100ps

`include "host_boot_macros.svh"

module dmem_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  booted,
    input  logic                  ld_wr_en,
    input  dmem_pkg::byte_addr_t  ld_wr_addr,
    input  dmem_pkg::word_t       ld_wr_data,
    input  dmem_pkg::byte_addr_t  accel_addr,
    input  dmem_pkg::word_t       accel_wrt_data,
    input  logic                  accel_wrt_en,
    input  logic                  accel_rd_en,
    input  dmem_pkg::line_t       rd_line,
    output logic                  mem_wr_en,
    output dmem_pkg::word_idx_t   mem_wr_idx,
    output dmem_pkg::word_t       mem_wr_data,
    output logic                  mem_rd_en,
    output logic [8:0]            mem_rd_line,
    output logic                  accel_wrt_done,
    output logic                  accel_rd_valid,
    output dmem_pkg::line_t       accel_rd_data
);

    localparam int WORD_SHIFT = $clog2(`HBM_WORD_BYTES);
    localparam int LINE_SHIFT = $clog2(`HBM_WORD_BYTES * `HBM_LINE_WORDS);
    localparam int IDX_BITS   = $bits(dmem_pkg::word_idx_t);

    dmem_pkg::byte_addr_t  wr_addr;
    logic                  acc_wr;
    logic                  acc_rd;

    assign acc_wr = booted && accel_wrt_en;     // ignored during boot
    assign acc_rd = booted && accel_rd_en;

    // write port select
    assign mem_wr_en   = booted ? accel_wrt_en   : ld_wr_en;
    assign wr_addr     = booted ? accel_addr     : ld_wr_addr;
    assign mem_wr_data = booted ? accel_wrt_data : ld_wr_data;
    assign mem_wr_idx  = wr_addr[WORD_SHIFT +: IDX_BITS];

    // line read, address aligned down to 64 bytes
    assign mem_rd_en   = acc_rd;
    assign mem_rd_line = accel_addr[LINE_SHIFT +: 9];

    // pulses line up with the memory's one cycle latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accel_wrt_done <= 1'b0;
            accel_rd_valid <= 1'b0;
        end else begin
            accel_wrt_done <= acc_wr;
            accel_rd_valid <= acc_rd;
        end
    end

    assign accel_rd_data = rd_line;

endmodule

// File: rtl/boot_loader.sv
// boot loader
// requests each data memory region from the host in turn and turns
// the returned words into a memory write stream, then parks in run

`timescale 1ns/100ps

`include "host_boot_macros.svh"

module boot_loader (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ready,
    input  logic                  rd_valid,
    input  logic                  tx_done,
    input  dmem_pkg::word_t       ex_wrt_data,
    output host_pkg::host_op_t    op,
    output dmem_pkg::byte_addr_t  ex_addr,
    output logic                  booted,
    output logic                  ld_wr_en,
    output dmem_pkg::byte_addr_t  ld_wr_addr,
    output dmem_pkg::word_t       ld_wr_data
);

    localparam dmem_pkg::byte_addr_t WORD_STEP = `HBM_WORD_BYTES;
    localparam host_pkg::region_idx_t LAST_REGION =
        host_pkg::region_idx_t'(`HBM_NUM_REGIONS - 1);

    host_pkg::boot_state_t  state;
    host_pkg::boot_state_t  state_nxt;
    host_pkg::region_idx_t  region;         // region being fetched
    dmem_pkg::byte_addr_t   word_addr;      // address of next streamed word
    dmem_pkg::byte_addr_t   region_base;
    logic                   last_region;
    logic                   first_word;     // rd_valid while waiting
    logic                   region_end;     // tx_done while loading

    assign region_base = host_pkg::BOOT_REGION_BASE[region];
    assign last_region = (region == LAST_REGION);
    assign first_word  = (state == host_pkg::BOOT_WAIT) && rd_valid;
    assign region_end  = (state == host_pkg::BOOT_LOAD) && tx_done;

    //////////////////////////////////////////////////////////////////////
    // state register and counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= host_pkg::BOOT_IDLE;
            region    <= '0;
            word_addr <= '0;
        end else begin
            state <= state_nxt;

            // first word goes to the base, stream carries on after it
            if (first_word)
                word_addr <= region_base + WORD_STEP;
            else if (state == host_pkg::BOOT_LOAD)
                word_addr <= word_addr + WORD_STEP;

            if (region_end && !last_region)
                region <= region + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            host_pkg::BOOT_IDLE: begin
                if (ready)
                    state_nxt = host_pkg::BOOT_WAIT;
            end
            host_pkg::BOOT_WAIT: begin
                if (rd_valid)
                    state_nxt = host_pkg::BOOT_LOAD;
            end
            host_pkg::BOOT_LOAD: begin
                if (tx_done)
                    state_nxt = last_region ? host_pkg::BOOT_RUN : host_pkg::BOOT_WAIT;
            end
            default: state_nxt = host_pkg::BOOT_RUN;   // run is final
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // host request and memory write stream
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        op         = host_pkg::HOST_IDLE;
        ex_addr    = '0;
        ld_wr_en   = 1'b0;
        ld_wr_addr = word_addr;
        case (state)
            host_pkg::BOOT_WAIT: begin
                op         = host_pkg::HOST_READ;
                ex_addr    = region_base;
                ld_wr_en   = rd_valid;
                ld_wr_addr = region_base;   // first word lands on the base
            end
            host_pkg::BOOT_LOAD: begin
                op       = host_pkg::HOST_READ;
                ex_addr  = region_base;     // base held for the whole transfer
                ld_wr_en = 1'b1;
            end
            default: ;
        endcase
    end

    assign ld_wr_data = ex_wrt_data;    // host word written in its own cycle
    assign booted     = (state == host_pkg::BOOT_RUN);

endmodule

// File: rtl/host_pkg.sv
// host protocol definitions
// request codes, boot FSM states and the table of boot region bases

`include "host_boot_macros.svh"

package host_pkg;

    // request code driven on op
    typedef enum logic [1:0] {
        HOST_IDLE = 2'b00,
        HOST_READ = 2'b01
    } host_op_t;

    // boot loader states
    typedef enum logic [1:0] {
        BOOT_IDLE,      // waiting for host ready
        BOOT_WAIT,      // region requested, waiting for first word
        BOOT_LOAD,      // one word per cycle until tx_done
        BOOT_RUN        // image loaded, stays here
    } boot_state_t;

    typedef logic [4:0] region_idx_t;

    // byte base of each region, fetched in this order
    localparam dmem_pkg::byte_addr_t BOOT_REGION_BASE [0:`HBM_NUM_REGIONS-1] = '{
        16'h1000, 16'h1040, 16'h1100, 16'h1140,
        16'h2000, 16'h2040, 16'h2100, 16'h2140,
        16'h3000, 16'h3040, 16'h3100, 16'h3140,
        16'h4000, 16'h4040, 16'h4100, 16'h4140,
        16'h0100    // last region sits low
    };

endpackage

// File: rtl/dmem_pkg.sv
// data memory types
// words, byte addresses, word indices and accelerator lines

`include "host_boot_macros.svh"

package dmem_pkg;

    // one data word
    typedef logic [`HBM_WORD_BITS-1:0] word_t;

    // byte address as seen by host and accelerator
    typedef logic [`HBM_ADDR_BITS-1:0] byte_addr_t;

    // word index into the whole memory
    typedef logic [$clog2(`HBM_DM_WORDS)-1:0] word_idx_t;

    // full accelerator line
    // word 0 sits in the lowest bits
    typedef logic [`HBM_LINE_WORDS*`HBM_WORD_BITS-1:0] line_t;

endpackage

// File: rtl/host_boot_macros.svh
// host boot memory geometry
// word, line and boot region sizes shared by the packages and the RTL

`ifndef HOST_BOOT_MACROS_SVH
`define HOST_BOOT_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// data path widths
//////////////////////////////////////////////////////////////////////

`define HBM_WORD_BITS   32      // data word
`define HBM_ADDR_BITS   16      // byte address, host and accelerator
`define HBM_WORD_BYTES  4       // bytes per data word

//////////////////////////////////////////////////////////////////////
// memory and line shape
//////////////////////////////////////////////////////////////////////

`define HBM_LINE_WORDS  16      // one accelerator line, 64 bytes
`define HBM_DM_WORDS    8192    // 32 KB data memory

// host fetches the data image in this many fixed regions
`define HBM_NUM_REGIONS 17

`endif
